//--- design/mem_pkg.sv
package mem_pkg;

   // default geometry of the register file, 16 words of 8 bits.
   localparam int ADDR_W_DEF = 4;
   localparam int DATA_W_DEF = 8;

   // operation decoded from the activate, write and read strobes.
   // op_idle covers both a low activate and an activated cycle with
   // neither strobe set.
   typedef enum logic [1:0] {
      op_idle       = 2'b00,
      op_write      = 2'b01,
      op_read       = 2'b10,
      op_read_write = 2'b11
   } mem_op_e;

endpackage : mem_pkg

//--- design/mem_req_if.sv
`timescale 1ns/1ps

// one decoded request per clock from the capture stage to the storage stage.
interface mem_req_if #(
   parameter int ADDR_W = mem_pkg::ADDR_W_DEF,
   parameter int DATA_W = mem_pkg::DATA_W_DEF
);
   import mem_pkg::*;

   mem_op_e             op;      // op_idle means no request this cycle.
   logic [ADDR_W-1:0]   waddr;
   logic [ADDR_W-1:0]   raddr;
   logic [DATA_W-1:0]   wdata;
   logic                collide; // read and write on the same word.

   modport src (
      output op,
      output waddr,
      output raddr,
      output wdata,
      output collide
   );

   modport dst (
      input  op,
      input  waddr,
      input  raddr,
      input  wdata,
      input  collide
   );

endinterface : mem_req_if

//--- design/mem_capture.sv
`timescale 1ns/1ps

module mem_capture #(
   parameter int ADDR_W = mem_pkg::ADDR_W_DEF,
   parameter int DATA_W = mem_pkg::DATA_W_DEF
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              activate,
   input  logic              write,
   input  logic              read,
   input  logic [ADDR_W-1:0] addrin,
   input  logic [ADDR_W-1:0] addrout,
   input  logic [DATA_W-1:0] datain,
   mem_req_if.src            req
);
   import mem_pkg::*;

   mem_op_e op_next;
   logic    collide_next;
   logic    same_addr;

   // activate gates both strobes.
   function automatic mem_op_e decode_op(
      input logic act,
      input logic wr,
      input logic rd
   );
      mem_op_e op;
      op = op_idle;
      if (act) begin
         case ({wr, rd})
            2'b10:   op = op_write;
            2'b01:   op = op_read;
            2'b11:   op = op_read_write;
            default: op = op_idle;
         endcase
      end
      return op;
   endfunction

   assign op_next      = decode_op(activate, write, read);
   assign same_addr    = (addrin == addrout);
   // only a cycle that both reads and writes can collide.
   assign collide_next = (op_next == op_read_write) && same_addr;

   // control half of the request register.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req.op      <= op_idle;
         req.collide <= 1'b0;
      end else begin
         req.op      <= op_next;
         req.collide <= collide_next;
      end
   end

   // payload half, taken every cycle whatever the op.
   always_ff @(posedge clk) begin
      req.waddr <= addrin;
      req.raddr <= addrout;
      req.wdata <= datain;
   end

endmodule : mem_capture

//--- design/mem_array.sv
`timescale 1ns/1ps

module mem_array #(
   parameter int ADDR_W = mem_pkg::ADDR_W_DEF,
   parameter int DATA_W = mem_pkg::DATA_W_DEF
) (
   input  logic              clk,
   input  logic              rst_n,
   mem_req_if.dst            req,
   output logic [DATA_W-1:0] dataout,
   output logic              error
);
   import mem_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] words [DEPTH];
   logic              wr_en;
   logic              rd_en;

   // op decode for the storage side.
   always_comb begin
      wr_en = 1'b0;
      rd_en = 1'b0;
      unique case (req.op)
         op_write: begin
            wr_en = 1'b1;
         end
         op_read: begin
            rd_en = 1'b1;
         end
         op_read_write: begin
            wr_en = 1'b1;
            rd_en = 1'b1;
         end
         default: begin
            wr_en = 1'b0;
            rd_en = 1'b0;
         end
      endcase
   end

   // storage array, every word cleared on reset.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            words[i] <= '0;
         end
      end else if (wr_en) begin
         words[req.waddr] <= req.wdata;
      end
   end

   // Read register. The array is sampled before this edge's write lands,
   // so a colliding read returns the old word.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dataout <= '0;
      end else if (rd_en) begin
         dataout <= words[req.raddr];
      end
   end

   // one cycle per colliding request.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         error <= 1'b0;
      end else begin
         error <= req.collide;
      end
   end

endmodule : mem_array

//--- design/mem_top.sv
`timescale 1ns/1ps

module mem_top #(
   parameter int ADDR_W = mem_pkg::ADDR_W_DEF,
   parameter int DATA_W = mem_pkg::DATA_W_DEF
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              activate,
   input  logic              write,
   input  logic              read,
   input  logic [ADDR_W-1:0] addrin,
   input  logic [ADDR_W-1:0] addrout,
   input  logic [DATA_W-1:0] datain,
   output logic [DATA_W-1:0] dataout,
   output logic              error
);

   // request bus between the two stages.
   mem_req_if #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) req_if ();

   // stage 1: sample and decode.
   mem_capture #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_capture (
      .clk      (clk),
      .rst_n    (rst_n),
      .activate (activate),
      .write    (write),
      .read     (read),
      .addrin   (addrin),
      .addrout  (addrout),
      .datain   (datain),
      .req      (req_if.src)
   );

   // stage 2: storage, read register and error flag.
   mem_array #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req_if.dst),
      .dataout (dataout),
      .error   (error)
   );

endmodule : mem_top

//--- tb/mem_assertions.sv
`timescale 1ns/1ps

module mem_assertions #(
   parameter int DATA_W = mem_pkg::DATA_W_DEF
) (
   input logic              clk,
   input logic              rst_n,
   input mem_pkg::mem_op_e  op,
   input logic [DATA_W-1:0] dataout,
   input logic              error
);
   import mem_pkg::*;

   int fail_count = 0;  // read by the testbench at the end of the run.

   // error is clear while in reset and on the edge after.
   reset_error_low: assert property (@(posedge clk) !rst_n |-> !error ##1 !error)
      else begin
         $error("error high around reset");
         fail_count++;
      end

   error_from_collision: assert property (
      @(posedge clk) disable iff (!rst_n)
      error |-> ($past(op) == op_read_write)
   ) else begin
      $error("error without a read-write request");
      fail_count++;
   end

   // dataout only moves on a read.
   dataout_holds: assert property (
      @(posedge clk) disable iff (!rst_n)
      (($past(op) != op_read) && ($past(op) != op_read_write)) |-> $stable(dataout)
   ) else begin
      $error("dataout changed without a read");
      fail_count++;
   end

endmodule : mem_assertions

bind mem_array mem_assertions #(
   .DATA_W (DATA_W)
) u_assertions (
   .clk     (clk),
   .rst_n   (rst_n),
   .op      (req.op),
   .dataout (dataout),
   .error   (error)
);

//--- tb/mem_tb.sv
`timescale 1ns/1ps

module mem_tb;
   import mem_pkg::*;

   localparam int ADDR_W       = ADDR_W_DEF;
   localparam int DATA_W       = DATA_W_DEF;
   localparam int DEPTH        = 1 << ADDR_W;
   localparam int RESET_CYCLES = 16;

   logic              clk;
   logic              rst_n;
   logic              activate;
   logic              write;
   logic              read;
   logic [ADDR_W-1:0] addrin;
   logic [ADDR_W-1:0] addrout;
   logic [DATA_W-1:0] datain;
   logic [DATA_W-1:0] dataout;
   logic              error;

   logic [DATA_W-1:0] model [DEPTH];
   logic [DATA_W-1:0] pipe_d [2];  // [0] result of the last request, [1] the one before.
   logic              pipe_e [2];
   logic [15:0]       lfsr_state;
   int                errors;
   int                passed;
   int                failed;

   mem_top #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .activate (activate),
      .write    (write),
      .read     (read),
      .addrin   (addrin),
      .addrout  (addrout),
      .datain   (datain),
      .dataout  (dataout),
      .error    (error)
   );

   always #4 clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic rand_data(output logic [DATA_W-1:0] v);
      for (int i = 0; i < DATA_W; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v[i] = lfsr_state[0];
      end
   endtask

   task automatic check_data(input logic [DATA_W-1:0] actual,
                             input logic [DATA_W-1:0] expected, input string what);
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, actual,
                  expected);
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, actual,
                  expected);
      end
   endtask

   task automatic clear_model();
      for (int a = 0; a < DEPTH; a++) begin
         model[a] = '0;
      end
      pipe_d[0] = '0;
      pipe_d[1] = '0;
      pipe_e[0] = 1'b0;
      pipe_e[1] = 1'b0;
   endtask

   // One request per falling edge. Results show up two rising edges after sampling.
   task automatic step(input logic act, input logic wr, input logic rd, input int wa,
                       input int ra, input logic [DATA_W-1:0] wd);
      logic              we;
      logic              re;
      logic              col;
      logic [DATA_W-1:0] rd_val;
      @(negedge clk);
      check_data(dataout, pipe_d[1], "dataout");
      check_flag(error, pipe_e[1], "error");
      we     = act & wr;
      re     = act & rd;
      col    = we & re & (wa[ADDR_W-1:0] == ra[ADDR_W-1:0]);
      rd_val = re ? model[ra[ADDR_W-1:0]] : pipe_d[0];  // old word, dataout holds otherwise.
      if (we) begin
         model[wa[ADDR_W-1:0]] = wd;
      end
      pipe_d[1] = pipe_d[0];
      pipe_e[1] = pipe_e[0];
      pipe_d[0] = rd_val;
      pipe_e[0] = col;
      activate  = act;
      write     = wr;
      read      = rd;
      addrin    = wa[ADDR_W-1:0];
      addrout   = ra[ADDR_W-1:0];
      datain    = wd;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         step(1'b0, 1'b0, 1'b0, 0, 0, '0);
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n    = 1'b0;
      activate = 1'b0;
      write    = 1'b0;
      read     = 1'b0;
      clear_model();
      for (int n = 0; n < RESET_CYCLES; n++) begin
         @(negedge clk);
         check_data(dataout, '0, "dataout in reset");
         check_flag(error, 1'b0, "error in reset");
      end
      rst_n = 1'b1;
   endtask

   task automatic end_test(input string name, input int err_start);
      if (errors == err_start) begin
         passed++;
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: %0d mismatches", name, errors - err_start);
      end
   endtask

   task automatic test_reset_contents();
      int e0;
      e0 = errors;
      for (int a = 0; a < DEPTH; a++) begin
         step(1'b1, 1'b0, 1'b1, 0, a, '0);
      end
      idle_cycles(2);
      end_test("reset contents", e0);
   endtask

   task automatic test_write_read();
      int                e0;
      logic [DATA_W-1:0] d;
      e0 = errors;
      for (int a = 0; a < DEPTH; a++) begin
         rand_data(d);
         step(1'b1, 1'b1, 1'b0, a, 0, d);
      end
      for (int a = 0; a < DEPTH; a++) begin
         step(1'b1, 1'b0, 1'b1, 0, a, '0);  // back to back.
      end
      idle_cycles(2);
      end_test("write then read", e0);
   endtask

   task automatic test_activate_gating();
      int                e0;
      logic [DATA_W-1:0] d;
      e0 = errors;
      for (int a = 0; a < 4; a++) begin
         rand_data(d);
         step(1'b0, 1'b1, 1'b1, a, a, d);
      end
      for (int a = 0; a < 4; a++) begin
         step(1'b1, 1'b0, 1'b1, 0, a, '0);
      end
      idle_cycles(2);
      end_test("activate gating", e0);
   endtask

   task automatic test_collision();
      int                e0;
      logic [DATA_W-1:0] d;
      e0 = errors;
      rand_data(d);
      step(1'b1, 1'b1, 1'b1, 5, 5, d);
      rand_data(d);
      step(1'b1, 1'b1, 1'b1, 6, 6, d);  // error stays high across both.
      step(1'b1, 1'b0, 1'b1, 0, 5, '0);
      step(1'b1, 1'b0, 1'b1, 0, 6, '0);
      idle_cycles(2);
      end_test("collision", e0);
   endtask

   task automatic test_split_access();
      int                e0;
      logic [DATA_W-1:0] d;
      e0 = errors;
      for (int a = 0; a < 4; a++) begin
         rand_data(d);
         step(1'b1, 1'b1, 1'b1, a, a + 8, d);
      end
      for (int a = 0; a < 4; a++) begin
         step(1'b1, 1'b0, 1'b1, 0, a, '0);
      end
      idle_cycles(2);
      end_test("split access", e0);
   endtask

   task automatic test_reset_mid_traffic();
      int                e0;
      logic [DATA_W-1:0] d;
      e0 = errors;
      for (int a = 0; a < 4; a++) begin
         rand_data(d);
         step(1'b1, 1'b1, 1'b1, a + 10, a, d);
      end
      apply_reset();
      for (int a = 0; a < DEPTH; a++) begin
         step(1'b1, 1'b0, 1'b1, 0, a, '0);
      end
      idle_cycles(2);
      end_test("reset mid traffic", e0);
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      activate   = 1'b0;
      write      = 1'b0;
      read       = 1'b0;
      addrin     = '0;
      addrout    = '0;
      datain     = '0;
      lfsr_state = 16'd32018;
      errors     = 0;
      passed     = 0;
      failed     = 0;
      apply_reset();
      test_reset_contents();
      test_write_read();
      test_activate_gating();
      test_collision();
      test_split_access();
      test_reset_mid_traffic();
      $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d", passed,
               failed, u_dut.u_array.u_assertions.fail_count);
      if (errors == 0 && failed == 0 && u_dut.u_array.u_assertions.fail_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule : mem_tb

//--- mem_top.f
design/mem_pkg.sv
design/mem_req_if.sv
design/mem_capture.sv
design/mem_array.sv
design/mem_top.sv
tb/mem_assertions.sv
tb/mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the mem_top testbench with Verilator.
set -u
set -o pipefail

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert --top-module mem_tb -Mdir "$BUILD" -f mem_top.f \
   && "./$BUILD/Vmem_tb" 2>&1 | tee "$LOG" \
   || { echo "build or simulation did not complete"; exit 1; }

grep -q '\*\* FAIL \*\*' "$LOG" \
   && { echo "simulation reported failure"; exit 1; } \
   || { echo "simulation reported no failure"; exit 0; }
